// File: source/isa_pkg.sv
package isa_pkg;

    localparam int WORD_W    = 16;
    localparam int OPCODE_W  = 5;
    localparam int FUNC_W    = 2;
    localparam int REG_IDX_W = 3;
    localparam int NUM_REGS  = 8;
    localparam int IMM5_W    = 5;
    localparam int IMM8_W    = 8;

    typedef logic [OPCODE_W-1:0]  opcode_t;
    typedef logic [FUNC_W-1:0]    func_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [WORD_W-1:0]    word_t;

    // low four values line up with the R-format shift func codes
    typedef enum logic [2:0] {
        ALU_ROL = 3'b000,
        ALU_SLL = 3'b001,
        ALU_ROR = 3'b010,
        ALU_SRL = 3'b011,
        ALU_ADD = 3'b100,
        ALU_OR  = 3'b101,
        ALU_XOR = 3'b110,
        ALU_AND = 3'b111
    } alu_op_t;

    localparam opcode_t OP_HALT    = 5'b00000;
    localparam opcode_t OP_NOP     = 5'b00001;
    localparam opcode_t OP_ADDI    = 5'b01000;
    localparam opcode_t OP_SUBI    = 5'b01001;
    localparam opcode_t OP_XORI    = 5'b01010;
    localparam opcode_t OP_ANDNI   = 5'b01011;
    localparam opcode_t OP_ROLI    = 5'b10100;
    localparam opcode_t OP_SLLI    = 5'b10101;
    localparam opcode_t OP_RORI    = 5'b10110;
    localparam opcode_t OP_SRLI    = 5'b10111;
    localparam opcode_t OP_SLBI    = 5'b10010;
    localparam opcode_t OP_LBI     = 5'b11000;
    localparam opcode_t OP_BTR     = 5'b11001;
    localparam opcode_t OP_SHIFT_R = 5'b11010;
    localparam opcode_t OP_ALU_R   = 5'b11011;
    localparam opcode_t OP_SEQ     = 5'b11100;
    localparam opcode_t OP_SLT     = 5'b11101;
    localparam opcode_t OP_SLE     = 5'b11110;

    // func under OP_ALU_R
    localparam func_t FN_ADD  = 2'b00;
    localparam func_t FN_SUB  = 2'b01;
    localparam func_t FN_XOR  = 2'b10;
    localparam func_t FN_ANDN = 2'b11;

    // func under OP_SHIFT_R
    localparam func_t FN_ROL = 2'b00;
    localparam func_t FN_SLL = 2'b01;
    localparam func_t FN_ROR = 2'b10;
    localparam func_t FN_SRL = 2'b11;

endpackage

// File: source/pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [1:0] {
        SET_EQ = 2'b00,
        SET_LT = 2'b01,
        SET_LE = 2'b10
    } set_kind_t;

    typedef struct packed {
        isa_pkg::alu_op_t aluop;
        logic             alusrc;
        logic             zeroext;
        // destination field select
        logic             i1;
        logic             i2;
        logic             r;
        logic             regwrite;
        logic             set;
        logic             btr;
        logic             slbi;
        logic             lbi;
        logic             invA;
        logic             invB;
        logic             cin;
        logic             halt;
        set_kind_t        set_kind;
    } ctrl_t;

    typedef struct packed {
        logic               valid;
        ctrl_t              ctrl;
        isa_pkg::word_t     rs_val;
        isa_pkg::word_t     rt_val;
        isa_pkg::word_t     imm;
        isa_pkg::reg_idx_t  dest;
    } dec_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::reg_idx_t  dest;
        isa_pkg::word_t     data;
    } res_t;

endpackage

// File: source/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  isa_pkg::opcode_t opcode,
    input  isa_pkg::func_t   func,
    output pipe_pkg::ctrl_t  ctrl
);

    logic a, b, c, d, e, f, g;
    logic na, nb, nc, nd, ne, nf;
    isa_pkg::alu_op_t    alu_op;
    pipe_pkg::set_kind_t set_kind;

    assign {a, b, c, d, e} = opcode;
    assign {f, g}          = func;
    assign na = ~a;
    assign nb = ~b;
    assign nc = ~c;
    assign nd = ~d;
    assign ne = ~e;
    assign nf = ~f;

    // immediate ops, slbi and lbi take the imm as operand b
    assign ctrl.alusrc  = (a ^ b) | (a & b & nc & nd & ne);
    assign ctrl.i1      = (na & b & nc) | (a & nb & c);
    assign ctrl.i2      = (a & nb & nc & d & ne) | (a & b & nc & nd & ne);
    assign ctrl.r       = a & b & (c | d | e);
    assign ctrl.set     = a & b & c & ~(d & e);
    assign ctrl.btr     = a & b & nc & nd & e;
    assign ctrl.lbi     = a & b & nc & nd & ne;
    assign ctrl.slbi    = a & nb & nc & d & ne;
    assign ctrl.zeroext = (na & b & nc & d) | ctrl.slbi;
    assign ctrl.halt    = ~(|opcode);

    // unknown opcodes fall out of every term
    assign ctrl.regwrite = (na & b & nc) |
                           (a & nb & c) |
                           (a & nb & nc & d & ne) |
                           (a & b & nc) |
                           (a & b & c & ~(d & e));

    // subi, sub
    assign ctrl.invA = (na & b & nc & nd & e) | (a & b & nc & d & e & nf & g);
    // andni, andn, set compares
    assign ctrl.invB = (na & b & nc & d & e) | (a & b & nc & d & e & f & g) | ctrl.set;
    assign ctrl.cin  = (na & b & nc & nd & e) | (a & b & nc & d & e & nf & g) | ctrl.set;

    assign ctrl.aluop    = alu_op;
    assign ctrl.set_kind = set_kind;

    always_comb begin
        alu_op   = isa_pkg::ALU_ADD;
        set_kind = pipe_pkg::SET_EQ;
        case (opcode)
            isa_pkg::OP_ROLI:  alu_op = isa_pkg::ALU_ROL;
            isa_pkg::OP_SLLI:  alu_op = isa_pkg::ALU_SLL;
            isa_pkg::OP_RORI:  alu_op = isa_pkg::ALU_ROR;
            isa_pkg::OP_SRLI:  alu_op = isa_pkg::ALU_SRL;
            isa_pkg::OP_XORI:  alu_op = isa_pkg::ALU_XOR;
            isa_pkg::OP_ANDNI: alu_op = isa_pkg::ALU_AND;
            isa_pkg::OP_SLBI:  alu_op = isa_pkg::ALU_OR;
            isa_pkg::OP_SHIFT_R: begin
                case (func)
                    isa_pkg::FN_ROL: alu_op = isa_pkg::ALU_ROL;
                    isa_pkg::FN_SLL: alu_op = isa_pkg::ALU_SLL;
                    isa_pkg::FN_ROR: alu_op = isa_pkg::ALU_ROR;
                    default:         alu_op = isa_pkg::ALU_SRL;
                endcase
            end
            isa_pkg::OP_ALU_R: begin
                case (func)
                    isa_pkg::FN_XOR:  alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::FN_ANDN: alu_op = isa_pkg::ALU_AND;
                    default:          alu_op = isa_pkg::ALU_ADD;
                endcase
            end
            isa_pkg::OP_SLT: set_kind = pipe_pkg::SET_LT;
            isa_pkg::OP_SLE: set_kind = pipe_pkg::SET_LE;
            default: ;
        endcase
    end

endmodule

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
    input  isa_pkg::word_t   a,
    input  isa_pkg::word_t   b,
    input  isa_pkg::alu_op_t op,
    input  logic             invA,
    input  logic             invB,
    input  logic             cin,
    output isa_pkg::word_t   out,
    output logic             cout,
    output logic             ovf
);

    isa_pkg::word_t a_i;
    isa_pkg::word_t b_i;
    isa_pkg::word_t sum;
    logic [3:0]     amt;
    logic [31:0]    dbl;
    logic [31:0]    rol_w;
    logic [31:0]    ror_w;

    assign a_i = invA ? ~a : a;
    assign b_i = invB ? ~b : b;

    assign {cout, sum} = {1'b0, a_i} + {1'b0, b_i} + {16'd0, cin};

    // both addends share a sign but the sum does not
    assign ovf = (a_i[15] == b_i[15]) && (sum[15] != a_i[15]);

    // rotates from a doubled copy of the operand
    assign amt   = b_i[3:0];
    assign dbl   = {a_i, a_i};
    assign rol_w = dbl << amt;
    assign ror_w = dbl >> amt;

    always_comb begin
        case (op)
            isa_pkg::ALU_ROL: out = rol_w[31:16];
            isa_pkg::ALU_SLL: out = a_i << amt;
            isa_pkg::ALU_ROR: out = ror_w[15:0];
            isa_pkg::ALU_SRL: out = a_i >> amt;
            isa_pkg::ALU_ADD: out = sum;
            isa_pkg::ALU_OR:  out = a_i | b_i;
            isa_pkg::ALU_XOR: out = a_i ^ b_i;
            default:          out = a_i & b_i;
        endcase
    end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  isa_pkg::word_t    instr,
    input  pipe_pkg::res_t    exe_res,
    input  pipe_pkg::res_t    res_q,
    output pipe_pkg::dec_t    dec_q,
    output logic              halted
);

    localparam int EXT5_W = isa_pkg::WORD_W - isa_pkg::IMM5_W;
    localparam int EXT8_W = isa_pkg::WORD_W - isa_pkg::IMM8_W;

    pipe_pkg::ctrl_t   ctrl;
    pipe_pkg::dec_t    dec_d;
    isa_pkg::word_t    rf [isa_pkg::NUM_REGS];
    isa_pkg::reg_idx_t rs_idx;
    isa_pkg::reg_idx_t rt_idx;
    logic              ext5;
    logic              ext8;
    logic              accept;

    // newest producer wins
    function automatic isa_pkg::word_t fwd_read(
        input isa_pkg::reg_idx_t idx,
        input pipe_pkg::res_t    one_back,
        input pipe_pkg::res_t    two_back,
        input isa_pkg::word_t    stored
    );
        if (one_back.valid && one_back.dest == idx) begin
            return one_back.data;
        end
        if (two_back.valid && two_back.dest == idx) begin
            return two_back.data;
        end
        return stored;
    endfunction

    control_unit control_unit_i (
        .opcode (instr[15:11]),
        .func   (instr[1:0]),
        .ctrl   (ctrl)
    );

    assign rs_idx = instr[10:8];
    assign rt_idx = instr[7:5];
    assign ext5   = ~ctrl.zeroext & instr[isa_pkg::IMM5_W-1];
    assign ext8   = ~ctrl.zeroext & instr[isa_pkg::IMM8_W-1];

    // a halt already in decode blocks the next instruction too
    assign accept = in_valid & ~halted & ~(dec_q.valid & dec_q.ctrl.halt);

    always_comb begin
        dec_d.valid  = accept;
        dec_d.ctrl   = ctrl;
        dec_d.rs_val = fwd_read(rs_idx, exe_res, res_q, rf[rs_idx]);
        dec_d.rt_val = fwd_read(rt_idx, exe_res, res_q, rf[rt_idx]);
        if (ctrl.i2) begin
            dec_d.imm = {{EXT8_W{ext8}}, instr[isa_pkg::IMM8_W-1:0]};
        end else begin
            dec_d.imm = {{EXT5_W{ext5}}, instr[isa_pkg::IMM5_W-1:0]};
        end
        if (ctrl.i1) begin
            dec_d.dest = instr[7:5];
        end else if (ctrl.i2) begin
            dec_d.dest = instr[10:8];
        end else if (ctrl.r) begin
            dec_d.dest = instr[4:2];
        end else begin
            dec_d.dest = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_q.valid <= 1'b0;
        end else begin
            dec_q <= dec_d;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (dec_q.valid && dec_q.ctrl.halt) begin
            halted <= 1'b1;
        end
    end

    // write-back two edges after capture
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (res_q.valid) begin
            rf[res_q.dest] <= res_q.data;
        end
    end

    a_in_valid_known : assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(in_valid)
    );

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic            clk,
    input  logic            arst_n,
    input  pipe_pkg::dec_t  dec_q,
    output pipe_pkg::res_t  exe_res,
    output pipe_pkg::res_t  res_q
);

    isa_pkg::word_t a_op;
    isa_pkg::word_t b_op;
    isa_pkg::word_t alu_out;
    isa_pkg::word_t rev;
    logic           alu_ovf;
    logic           is_zero;
    logic           is_lt;
    logic           set_bit;

    // slbi merges through the or path
    assign a_op = dec_q.ctrl.slbi ? (dec_q.rs_val << 8) : dec_q.rs_val;
    assign b_op = dec_q.ctrl.alusrc ? dec_q.imm : dec_q.rt_val;

    alu alu_i (
        .a    (a_op),
        .b    (b_op),
        .op   (dec_q.ctrl.aluop),
        .invA (dec_q.ctrl.invA),
        .invB (dec_q.ctrl.invB),
        .cin  (dec_q.ctrl.cin),
        .out  (alu_out),
        .cout (),
        .ovf  (alu_ovf)
    );

    // rs minus rt
    assign is_zero = (alu_out == '0);
    assign is_lt   = alu_out[15] ^ alu_ovf;

    always_comb begin
        case (dec_q.ctrl.set_kind)
            pipe_pkg::SET_EQ: set_bit = is_zero;
            pipe_pkg::SET_LT: set_bit = is_lt;
            default:          set_bit = is_lt | is_zero;
        endcase
    end

    always_comb begin
        for (int i = 0; i < isa_pkg::WORD_W; i++) begin
            rev[i] = dec_q.rs_val[isa_pkg::WORD_W-1-i];
        end
    end

    always_comb begin
        exe_res.valid = dec_q.valid & dec_q.ctrl.regwrite;
        exe_res.dest  = dec_q.dest;
        if (dec_q.ctrl.lbi) begin
            exe_res.data = dec_q.imm;
        end else if (dec_q.ctrl.btr) begin
            exe_res.data = rev;
        end else if (dec_q.ctrl.set) begin
            exe_res.data = {15'd0, set_bit};
        end else begin
            exe_res.data = alu_out;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_q.valid <= 1'b0;
        end else begin
            res_q <= exe_res;
        end
    end

    a_set_is_bool : assert property (
        @(posedge clk) disable iff (!arst_n)
        (exe_res.valid && dec_q.ctrl.set) |=> (res_q.data[15:1] == '0)
    );

endmodule

// File: source/ace_pipe_top.sv
`timescale 1ns/1ps

module ace_pipe_top (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            in_valid,
    input  isa_pkg::word_t  instr,
    output pipe_pkg::res_t  result,
    output logic            halted
);

    pipe_pkg::dec_t dec_q;
    pipe_pkg::res_t exe_res;

    // result doubles as the write-back bus
    decode_stage decode_stage_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .instr    (instr),
        .exe_res  (exe_res),
        .res_q    (result),
        .dec_q    (dec_q),
        .halted   (halted)
    );

    execute_stage execute_stage_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .dec_q   (dec_q),
        .exe_res (exe_res),
        .res_q   (result)
    );

endmodule

// File: verif/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

typedef logic [7:0][15:0] reg_file_t;

typedef struct packed {
    logic              wr;
    isa_pkg::reg_idx_t dest;
    isa_pkg::word_t    value;
} ref_res_t;

function automatic logic [15:0] rol16(input logic [15:0] v, input logic [3:0] n);
    return (v << n) | (v >> (5'd16 - {1'b0, n}));
endfunction

function automatic logic [15:0] ror16(input logic [15:0] v, input logic [3:0] n);
    return (v >> n) | (v << (5'd16 - {1'b0, n}));
endfunction

// one instruction against the model registers, in program order
function automatic ref_res_t ref_exec(input logic [15:0] ins, input reg_file_t regs);
    ref_res_t    res;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] simm5;
    logic [15:0] zimm5;
    logic [15:0] simm8;
    logic [15:0] rev;
    a     = regs[ins[10:8]];
    b     = regs[ins[7:5]];
    simm5 = {{11{ins[4]}}, ins[4:0]};
    zimm5 = {11'd0, ins[4:0]};
    simm8 = {{8{ins[7]}}, ins[7:0]};
    rev   = {<<{a}};
    res.wr    = 1'b1;
    res.dest  = ins[7:5];
    res.value = '0;
    case (ins[15:11])
        isa_pkg::OP_ADDI:  res.value = a + simm5;
        isa_pkg::OP_SUBI:  res.value = simm5 - a;
        isa_pkg::OP_XORI:  res.value = a ^ zimm5;
        isa_pkg::OP_ANDNI: res.value = a & ~zimm5;
        isa_pkg::OP_ROLI:  res.value = rol16(a, ins[3:0]);
        isa_pkg::OP_SLLI:  res.value = a << ins[3:0];
        isa_pkg::OP_RORI:  res.value = ror16(a, ins[3:0]);
        isa_pkg::OP_SRLI:  res.value = a >> ins[3:0];
        isa_pkg::OP_LBI:   res.value = simm8;
        isa_pkg::OP_SLBI:  res.value = {a[7:0], ins[7:0]};
        isa_pkg::OP_BTR:   res.value = rev;
        isa_pkg::OP_SEQ:   res.value = {15'd0, (a == b)};
        isa_pkg::OP_SLT:   res.value = {15'd0, ($signed(a) < $signed(b))};
        isa_pkg::OP_SLE:   res.value = {15'd0, ($signed(a) <= $signed(b))};
        isa_pkg::OP_SHIFT_R: begin
            case (ins[1:0])
                isa_pkg::FN_ROL: res.value = rol16(a, b[3:0]);
                isa_pkg::FN_SLL: res.value = a << b[3:0];
                isa_pkg::FN_ROR: res.value = ror16(a, b[3:0]);
                default:         res.value = a >> b[3:0];
            endcase
        end
        isa_pkg::OP_ALU_R: begin
            case (ins[1:0])
                isa_pkg::FN_ADD: res.value = a + b;
                isa_pkg::FN_SUB: res.value = b - a;
                isa_pkg::FN_XOR: res.value = a ^ b;
                default:         res.value = a & ~b;
            endcase
        end
        default: res.wr = 1'b0;
    endcase
    // lbi and slbi write rs, r-format writes the low field
    if (ins[15:11] inside {isa_pkg::OP_LBI, isa_pkg::OP_SLBI}) begin
        res.dest = ins[10:8];
    end else if (ins[15:11] inside {isa_pkg::OP_BTR, isa_pkg::OP_SHIFT_R, isa_pkg::OP_ALU_R,
                                    isa_pkg::OP_SEQ, isa_pkg::OP_SLT, isa_pkg::OP_SLE}) begin
        res.dest = ins[4:2];
    end
    return res;
endfunction

`endif

// File: verif/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    `include "tb_ref.svh"

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int T2_REPS      = 6;
    localparam int T3_REPS      = 4;
    localparam int T4_RANDOM    = 24;
    localparam int CHAIN_LEN    = 40;
    localparam int DRAIN_LIMIT  = 16;
    // chain gaps count up to two idle cycles per instruction
    localparam int ISSUE_CYCLES = 16 + 8 * T2_REPS + 16 + 8 * T3_REPS + 33 + T4_RANDOM
                                + 4 * CHAIN_LEN + 45;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + ISSUE_CYCLES + 6 * DRAIN_LIMIT + 100)
                                * CLK_PERIOD;

    localparam logic [7:0][15:0] CONSTS = {
        16'h8000, 16'h7fff, 16'hffff, 16'h0000,
        16'h1234, 16'habcd, 16'h00ff, 16'h5a5a
    };
    localparam logic [7:0][4:0] IMM_OPS = {
        isa_pkg::OP_SRLI, isa_pkg::OP_RORI, isa_pkg::OP_SLLI, isa_pkg::OP_ROLI,
        isa_pkg::OP_ANDNI, isa_pkg::OP_XORI, isa_pkg::OP_SUBI, isa_pkg::OP_ADDI
    };
    localparam logic [3:0][4:0] CMP_OPS = {
        isa_pkg::OP_BTR, isa_pkg::OP_SLE, isa_pkg::OP_SLT, isa_pkg::OP_SEQ
    };

    logic           clk = 1'b0;
    logic           arst_n;
    logic           in_valid;
    isa_pkg::word_t instr;
    pipe_pkg::res_t result;
    logic           halted;

    integer     seed = 46;
    int         checks = 0;
    int         errors = 0;
    int         checks_at_start;
    int         errors_at_start;
    reg_file_t  model_regs;
    logic       halt_sent;
    logic [2:0] dep1;
    logic [2:0] dep2;
    ref_res_t   exp_q [$];
    ref_res_t   expected;

    ace_pipe_top dut_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .instr    (instr),
        .result   (result),
        .halted   (halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [15:0] i5_instr(input logic [4:0] op, input logic [2:0] rs,
                                            input logic [2:0] rd, input logic [4:0] imm);
        return {op, rs, rd, imm};
    endfunction

    function automatic logic [15:0] i8_instr(input logic [4:0] op, input logic [2:0] rs,
                                            input logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic logic [15:0] r_instr(input logic [4:0] op, input logic [2:0] rs,
                                           input logic [2:0] rt, input logic [2:0] rd,
                                           input logic [1:0] fn);
        return {op, rs, rt, rd, fn};
    endfunction

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // sources lean on the last two destinations
    function automatic logic [15:0] random_instr();
        logic [31:0] r;
        r = rand32();
        case (r[2:0])
            3'd0, 3'd1: return i5_instr(IMM_OPS[r[6:4]], dep1, r[10:8], r[15:11]);
            3'd2:       return r_instr(isa_pkg::OP_ALU_R, dep1, dep2, r[10:8], r[5:4]);
            3'd3:       return r_instr(isa_pkg::OP_SHIFT_R, dep2, dep1, r[10:8], r[5:4]);
            3'd4:       return r_instr(CMP_OPS[r[5:4]], dep1, dep2, r[10:8], 2'b00);
            3'd5:       return i8_instr(isa_pkg::OP_SLBI, dep1, r[23:16]);
            3'd6:       return i8_instr(isa_pkg::OP_LBI, r[10:8], r[23:16]);
            default:    return i5_instr(IMM_OPS[r[6:4]], dep2, r[10:8], r[15:11]);
        endcase
    endfunction

    task automatic issue(input logic [15:0] ins);
        ref_res_t predicted;
        @(posedge clk);
        in_valid <= 1'b1;
        instr    <= ins;
        predicted = ref_exec(ins, model_regs);
        // nothing gets through once a halt is in
        if (predicted.wr && !halt_sent) begin
            exp_q.push_back(predicted);
            model_regs[predicted.dest] = predicted.value;
            dep2 = dep1;
            dep1 = predicted.dest;
        end
        if (ins[15:11] == isa_pkg::OP_HALT) begin
            halt_sent = 1'b1;
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic load_reg(input logic [2:0] r, input logic [15:0] value);
        issue(i8_instr(isa_pkg::OP_LBI, r, value[15:8]));
        issue(i8_instr(isa_pkg::OP_SLBI, r, value[7:0]));
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("ERROR: %0d expected results never appeared", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic start_test();
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    task automatic end_test(input int num, input string name);
        drain();
        $display("test %0d %s: %0d results checked, %0d errors", num, name,
                 checks - checks_at_start, errors - errors_at_start);
    endtask

    // registered result is stable at the falling edge
    always @(negedge clk) begin
        if (arst_n && result.valid) begin
            assert (exp_q.size() != 0) else begin
                $display("ERROR: result strobe for r%0d with no instruction outstanding",
                         result.dest);
                errors++;
            end
            if (exp_q.size() != 0) begin
                expected = exp_q.pop_front();
                checks++;
                assert (result.dest == expected.dest) else begin
                    $display("MISMATCH result.dest expected %h got %h",
                             expected.dest, result.dest);
                    errors++;
                end
                assert (result.data == expected.value) else begin
                    $display("MISMATCH result.data expected %h got %h",
                             expected.value, result.data);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        instr      = '0;
        model_regs = '0;
        halt_sent  = 1'b0;
        dep1       = 3'd0;
        dep2       = 3'd0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        idle(2);

        start_test();
        for (int i = 0; i < 8; i++) begin
            load_reg(3'(i), CONSTS[3'(i)]);
        end
        end_test(1, "lbi and slbi constants");

        start_test();
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < T2_REPS; k++) begin
                r = rand32();
                issue(i5_instr(IMM_OPS[3'(i)], r[2:0], r[5:3], r[10:6]));
            end
        end
        end_test(2, "immediate alu, shift and rotate");

        start_test();
        for (int i = 0; i < 8; i++) begin
            r = rand32();
            load_reg(3'(i), r[15:0]);
        end
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < T3_REPS; k++) begin
                r = rand32();
                issue(r_instr((i < 4) ? isa_pkg::OP_ALU_R : isa_pkg::OP_SHIFT_R,
                              r[2:0], r[5:3], r[8:6], 2'(i)));
            end
        end
        end_test(3, "r-format alu and shifts");

        start_test();
        for (int i = 0; i < 8; i++) begin
            r = rand32();
            load_reg(3'(i), r[15:0]);
        end
        // most-negative value in both r1 and r2
        load_reg(3'd1, 16'h8000);
        load_reg(3'd2, 16'h8000);
        for (int i = 0; i < 3; i++) begin
            issue(r_instr(CMP_OPS[2'(i)], 3'd1, 3'd2, 3'd7, 2'b00));
            issue(r_instr(CMP_OPS[2'(i)], 3'd1, 3'd3, 3'd7, 2'b00));
            issue(r_instr(CMP_OPS[2'(i)], 3'd3, 3'd1, 3'd7, 2'b00));
            issue(r_instr(CMP_OPS[2'(i)], 3'd4, 3'd4, 3'd7, 2'b00));
        end
        issue(r_instr(isa_pkg::OP_BTR, 3'd1, 3'd0, 3'd6, 2'b00));
        for (int k = 0; k < T4_RANDOM; k++) begin
            r = rand32();
            issue(r_instr(CMP_OPS[r[1:0]], r[4:2], r[20] ? r[4:2] : r[7:5],
                          r[10:8], 2'b00));
        end
        end_test(4, "set compares and btr");

        start_test();
        for (int k = 0; k < CHAIN_LEN; k++) begin
            issue(random_instr());
        end
        for (int k = 0; k < CHAIN_LEN; k++) begin
            issue(random_instr());
            r = rand32();
            idle(int'(r[1:0]) % 3);
        end
        end_test(5, "dependent chains");

        start_test();
        assert (!halted) else begin
            $display("ERROR: halted is high before any halt was issued");
            errors++;
        end
        for (int k = 0; k < 4; k++) begin
            issue(i5_instr(isa_pkg::OP_NOP, 3'(k), 3'(k + 1), 5'(k)));
        end
        idle(8);
        // two writers still in flight when the halt arrives
        issue(random_instr());
        issue(random_instr());
        issue(i5_instr(isa_pkg::OP_HALT, 3'd0, 3'd0, 5'd0));
        for (int k = 0; k < 8; k++) begin
            issue(random_instr());
        end
        idle(1);
        assert (halted) else begin
            $display("ERROR: halted did not rise after the halt instruction");
            errors++;
        end
        idle(10);
        assert (exp_q.size() == 0) else begin
            $display("ERROR: %0d results still outstanding after halt", exp_q.size());
            errors++;
        end
        end_test(6, "nop and halt");

        $display("%0d results checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+verif
source/isa_pkg.sv
source/pipe_pkg.sv
source/control_unit.sv
source/alu.sv
source/decode_stage.sv
source/execute_stage.sv
source/ace_pipe_top.sv
verif/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the pipeline testbench under verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_top -f compile.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_top > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0
